//--- design/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data path width
`define WORD_W 16

// 8 architectural registers
`define REG_IDX_W 3

// rob size, tag is the rename name
`define ROB_TAG_W 2
`define ROB_DEPTH 4

// identical reservation lanes
`define NUM_LANES 3

// multiplier latency in execute cycles
`define MUL_CYCLES 3

// immediate field, zero-extended on use
`define IMM_W 8

`endif

//--- design/core_pkg.sv
`include "core_defs.svh"

package core_pkg;

	////////////////////
	// plain vectors
	////////////////////

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`REG_IDX_W-1:0] reg_idx_t;
	typedef logic [`ROB_TAG_W-1:0] rob_tag_t;
	typedef logic [`IMM_W-1:0] imm_t;
	// one bit per lane
	typedef logic [`NUM_LANES-1:0] lane_mask_t;

	// supported operations
	typedef enum logic [2:0] {
		OP_LI,
		OP_ADD,
		OP_SUB,
		OP_XOR,
		OP_MUL
	} alu_op_t;

	// lane fsm
	typedef enum logic [1:0] {
		LANE_FREE,
		LANE_WAIT,
		LANE_EXEC,
		LANE_DONE
	} lane_state_t;

	////////////////////
	// packets
	////////////////////

	// decoded instruction from the testbench
	typedef struct packed {
		alu_op_t op;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		imm_t imm;
	} inst_t;

	// either a value or the tag it waits on
	typedef struct packed {
		logic ready;
		rob_tag_t tag;
		word_t value;
	} operand_t;

	// issue stage to one lane
	typedef struct packed {
		logic valid;
		alu_op_t op;
		rob_tag_t tag;
		operand_t src1;
		operand_t src2;
	} dispatch_t;

	// common data bus broadcast
	typedef struct packed {
		logic valid;
		rob_tag_t tag;
		word_t value;
	} cdb_t;

	// in-order retirement
	typedef struct packed {
		logic valid;
		reg_idx_t rd;
		word_t value;
	} commit_t;

endpackage

//--- design/issue_stage.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module issue_stage (
	input logic clock,
	input logic reset,
	input logic inst_valid,
	input core_pkg::inst_t inst,
	output logic issue_stall,
	input logic rob_full,
	input core_pkg::rob_tag_t rob_tail,
	output core_pkg::rob_tag_t rob_read_tag1,
	output core_pkg::rob_tag_t rob_read_tag2,
	input logic rob_read_ready1,
	input logic rob_read_ready2,
	input core_pkg::word_t rob_read_value1,
	input core_pkg::word_t rob_read_value2,
	output logic rob_alloc,
	output core_pkg::reg_idx_t rob_alloc_rd,
	input core_pkg::lane_mask_t lane_free,
	output core_pkg::dispatch_t dispatch [`NUM_LANES],
	input core_pkg::cdb_t cdb,
	input core_pkg::commit_t commit
);

	localparam int NUM_REGS = 1 << `REG_IDX_W;
	localparam int LANE_IDX_W = $clog2(`NUM_LANES);

	// architectural state and rename map
	core_pkg::word_t rf [NUM_REGS];
	logic [NUM_REGS-1:0] map_busy;
	core_pkg::rob_tag_t map_tag [NUM_REGS];
	// follows the rob head, commits retire in order
	core_pkg::rob_tag_t commit_tag;

	logic [LANE_IDX_W-1:0] sel;
	logic any_free;
	logic accept;
	core_pkg::operand_t src1;
	core_pkg::operand_t src2;
	core_pkg::word_t imm_ext;

	// rf, then rob, then cdb, else wait on tag
	function automatic core_pkg::operand_t resolve(input logic busy, input core_pkg::word_t rf_value,
			input core_pkg::rob_tag_t tag, input logic rob_ready,
			input core_pkg::word_t rob_value, input core_pkg::cdb_t bus);
		core_pkg::operand_t op;
		op = '{ready: 1'b1, tag: tag, value: rf_value};
		if (busy) begin
			if (rob_ready) op.value = rob_value;
			else if (bus.valid && bus.tag == tag) op.value = bus.value;
			else op.ready = 1'b0;
		end
		return op;
	endfunction

	////////////////////
	// lane select
	////////////////////

	// lowest free lane wins
	always_comb begin
		sel = '0;
		any_free = 1'b0;
		for (int i = `NUM_LANES - 1; i >= 0; i--) begin
			if (lane_free[i]) begin
				sel = LANE_IDX_W'(i);
				any_free = 1'b1;
			end
		end
	end

	assign issue_stall = rob_full || !any_free;
	assign accept = inst_valid && !issue_stall;
	assign rob_alloc = accept;
	assign rob_alloc_rd = inst.rd;
	assign rob_read_tag1 = map_tag[inst.rs1];
	assign rob_read_tag2 = map_tag[inst.rs2];
	assign imm_ext = {{(`WORD_W - `IMM_W){1'b0}}, inst.imm};

	////////////////////
	// operand build
	////////////////////

	always_comb begin
		src1 = resolve(map_busy[inst.rs1], rf[inst.rs1], rob_read_tag1, rob_read_ready1,
			rob_read_value1, cdb);
		src2 = resolve(map_busy[inst.rs2], rf[inst.rs2], rob_read_tag2, rob_read_ready2,
			rob_read_value2, cdb);
		// li carries its value in src1
		if (inst.op == core_pkg::OP_LI) begin
			src1 = '{ready: 1'b1, tag: '0, value: imm_ext};
			src2 = '{ready: 1'b1, tag: '0, value: '0};
		end
		for (int i = 0; i < `NUM_LANES; i++) begin
			dispatch[i] = '{valid: accept && (sel == LANE_IDX_W'(i)), op: inst.op,
				tag: rob_tail, src1: src1, src2: src2};
		end
	end

	////////////////////
	// commit and rename
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			map_busy <= '0;
			commit_tag <= '0;
			for (int r = 0; r < NUM_REGS; r++) begin
				rf[r] <= '0;
			end
		end else begin
			if (commit.valid) begin
				rf[commit.rd] <= commit.value;
				commit_tag <= commit_tag + 1'b1;
				// keep a newer rename mapped
				if (map_tag[commit.rd] == commit_tag) map_busy[commit.rd] <= 1'b0;
			end
			// new rename beats the clear
			if (accept) map_busy[inst.rd] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) map_tag[inst.rd] <= rob_tail;
	end

endmodule

//--- design/reservation_lane.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module reservation_lane (
	input logic clock,
	input logic reset,
	input core_pkg::dispatch_t dispatch,
	input core_pkg::cdb_t cdb,
	input logic grant,
	output logic lane_free,
	output logic request,
	output core_pkg::cdb_t result
);

	localparam int CNT_W = $clog2(`MUL_CYCLES) + 1;

	core_pkg::lane_state_t state;
	logic [CNT_W-1:0] count;
	// held instruction
	core_pkg::alu_op_t op_q;
	core_pkg::rob_tag_t tag_q;
	core_pkg::operand_t src1_q;
	core_pkg::operand_t src2_q;
	core_pkg::operand_t src1_next;
	core_pkg::operand_t src2_next;
	core_pkg::word_t alu_value;
	core_pkg::word_t result_value;

	// snoop the cdb for a pending operand
	function automatic core_pkg::operand_t capture(input core_pkg::operand_t src,
			input core_pkg::cdb_t bus);
		core_pkg::operand_t op;
		op = src;
		if (!src.ready && bus.valid && bus.tag == src.tag) begin
			op.ready = 1'b1;
			op.value = bus.value;
		end
		return op;
	endfunction

	// execute cycles minus one
	function automatic logic [CNT_W-1:0] start_count(input core_pkg::alu_op_t op);
		return (op == core_pkg::OP_MUL) ? CNT_W'(`MUL_CYCLES - 1) : '0;
	endfunction

	assign src1_next = capture(src1_q, cdb);
	assign src2_next = capture(src2_q, cdb);

	////////////////////
	// execute unit
	////////////////////

	always_comb begin
		case (op_q)
			core_pkg::OP_ADD: alu_value = src1_q.value + src2_q.value;
			core_pkg::OP_SUB: alu_value = src1_q.value - src2_q.value;
			core_pkg::OP_XOR: alu_value = src1_q.value ^ src2_q.value;
			// low word only
			core_pkg::OP_MUL: alu_value = src1_q.value * src2_q.value;
			default: alu_value = src1_q.value;
		endcase
	end

	////////////////////
	// lane fsm
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= core_pkg::LANE_FREE;
			count <= '0;
		end else begin
			case (state)
				core_pkg::LANE_FREE: if (dispatch.valid) begin
					state <= (dispatch.src1.ready && dispatch.src2.ready) ?
						core_pkg::LANE_EXEC : core_pkg::LANE_WAIT;
					count <= start_count(dispatch.op);
				end
				core_pkg::LANE_WAIT: if (src1_next.ready && src2_next.ready) begin
					state <= core_pkg::LANE_EXEC;
					count <= start_count(op_q);
				end
				core_pkg::LANE_EXEC: begin
					if (count == '0) state <= core_pkg::LANE_DONE;
					else count <= count - 1'b1;
				end
				// losers hold their result
				default: if (grant) state <= core_pkg::LANE_FREE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == core_pkg::LANE_FREE && dispatch.valid) begin
			op_q <= dispatch.op;
			tag_q <= dispatch.tag;
			src1_q <= dispatch.src1;
			src2_q <= dispatch.src2;
		end else if (state == core_pkg::LANE_WAIT) begin
			src1_q <= src1_next;
			src2_q <= src2_next;
		end
		if (state == core_pkg::LANE_EXEC && count == '0) result_value <= alu_value;
	end

	assign lane_free = state == core_pkg::LANE_FREE;
	assign request = state == core_pkg::LANE_DONE;
	assign result = '{valid: request, tag: tag_q, value: result_value};

endmodule

//--- design/cdb_arbiter.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module cdb_arbiter (
	input logic clock,
	input logic reset,
	input core_pkg::lane_mask_t request,
	input core_pkg::cdb_t results [`NUM_LANES],
	output core_pkg::lane_mask_t grant,
	output core_pkg::cdb_t cdb
);

	localparam int PTR_W = $clog2(`NUM_LANES);

	// last winner, search starts after it
	logic [PTR_W-1:0] last;
	logic [PTR_W-1:0] winner;
	logic found;

	////////////////////
	// round robin pick
	////////////////////

	always_comb begin
		int idx;
		winner = last;
		found = 1'b0;
		for (int i = 1; i <= `NUM_LANES; i++) begin
			idx = (int'(last) + i) % `NUM_LANES;
			if (!found && request[idx]) begin
				winner = PTR_W'(idx);
				found = 1'b1;
			end
		end
		grant = '0;
		if (found) grant[winner] = 1'b1;
	end

	////////////////////
	// registered bus
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			cdb.valid <= 1'b0;
			// lane 0 goes first
			last <= PTR_W'(`NUM_LANES - 1);
		end else begin
			cdb.valid <= found;
			if (found) last <= winner;
		end
		cdb.tag <= results[winner].tag;
		cdb.value <= results[winner].value;
	end

endmodule

//--- design/reorder_buffer.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module reorder_buffer (
	input logic clock,
	input logic reset,
	input logic alloc,
	input core_pkg::reg_idx_t alloc_rd,
	output logic full,
	output core_pkg::rob_tag_t tail,
	input core_pkg::rob_tag_t read_tag1,
	input core_pkg::rob_tag_t read_tag2,
	output logic read_ready1,
	output logic read_ready2,
	output core_pkg::word_t read_value1,
	output core_pkg::word_t read_value2,
	input core_pkg::cdb_t cdb,
	output core_pkg::commit_t commit
);

	localparam int CNT_W = $clog2(`ROB_DEPTH) + 1;

	// per-entry fields
	core_pkg::reg_idx_t entry_rd [`ROB_DEPTH];
	logic [`ROB_DEPTH-1:0] entry_ready;
	core_pkg::word_t entry_value [`ROB_DEPTH];

	// oldest entry
	core_pkg::rob_tag_t head;
	logic [CNT_W-1:0] count;
	logic retire;

	assign full = count == CNT_W'(`ROB_DEPTH);

	////////////////////
	// operand read
	////////////////////

	// cdb this cycle is bypassed in issue
	assign read_ready1 = entry_ready[read_tag1];
	assign read_ready2 = entry_ready[read_tag2];
	assign read_value1 = entry_value[read_tag1];
	assign read_value2 = entry_value[read_tag2];

	////////////////////
	// in-order commit
	////////////////////

	assign retire = (count != '0) && entry_ready[head];
	assign commit = '{valid: retire, rd: entry_rd[head], value: entry_value[head]};

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			entry_ready <= '0;
		end else begin
			if (alloc) begin
				entry_ready[tail] <= 1'b0;
				tail <= tail + 1'b1;
			end
			// result lands by tag
			if (cdb.valid) entry_ready[cdb.tag] <= 1'b1;
			if (retire) head <= head + 1'b1;
			case ({alloc, retire})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// destination and result payload
	always_ff @(posedge clock) begin
		if (alloc) entry_rd[tail] <= alloc_rd;
		if (cdb.valid) entry_value[cdb.tag] <= cdb.value;
	end

endmodule

//--- design/tomasulo_core.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module tomasulo_core (
	input logic clock,
	input logic reset,
	input logic inst_valid,
	input core_pkg::inst_t inst,
	output logic issue_stall,
	output core_pkg::commit_t commit
);

	// rob to issue
	logic rob_full;
	core_pkg::rob_tag_t rob_tail;
	core_pkg::rob_tag_t rob_read_tag1;
	core_pkg::rob_tag_t rob_read_tag2;
	logic rob_read_ready1;
	logic rob_read_ready2;
	core_pkg::word_t rob_read_value1;
	core_pkg::word_t rob_read_value2;
	logic rob_alloc;
	core_pkg::reg_idx_t rob_alloc_rd;

	// lanes, gathered for the arbiter
	core_pkg::dispatch_t dispatch [`NUM_LANES];
	core_pkg::cdb_t results [`NUM_LANES];
	core_pkg::lane_mask_t lane_free;
	core_pkg::lane_mask_t request;
	core_pkg::lane_mask_t grant;
	core_pkg::cdb_t cdb;

	////////////////////
	// issue and rob
	////////////////////

	issue_stage i_issue_stage (
		.clock(clock), .reset(reset),
		.inst_valid(inst_valid), .inst(inst), .issue_stall(issue_stall),
		.rob_full(rob_full), .rob_tail(rob_tail),
		.rob_read_tag1(rob_read_tag1), .rob_read_tag2(rob_read_tag2),
		.rob_read_ready1(rob_read_ready1), .rob_read_ready2(rob_read_ready2),
		.rob_read_value1(rob_read_value1), .rob_read_value2(rob_read_value2),
		.rob_alloc(rob_alloc), .rob_alloc_rd(rob_alloc_rd),
		.lane_free(lane_free), .dispatch(dispatch), .cdb(cdb), .commit(commit)
	);

	reorder_buffer i_reorder_buffer (
		.clock(clock), .reset(reset),
		.alloc(rob_alloc), .alloc_rd(rob_alloc_rd), .full(rob_full), .tail(rob_tail),
		.read_tag1(rob_read_tag1), .read_tag2(rob_read_tag2),
		.read_ready1(rob_read_ready1), .read_ready2(rob_read_ready2),
		.read_value1(rob_read_value1), .read_value2(rob_read_value2),
		.cdb(cdb), .commit(commit)
	);

	////////////////////
	// lanes and cdb
	////////////////////

	for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
		reservation_lane i_reservation_lane (
			.clock(clock), .reset(reset),
			.dispatch(dispatch[i]), .cdb(cdb), .grant(grant[i]),
			.lane_free(lane_free[i]), .request(request[i]), .result(results[i])
		);
	end

	cdb_arbiter i_cdb_arbiter (
		.clock(clock), .reset(reset),
		.request(request), .results(results), .grant(grant), .cdb(cdb)
	);

endmodule

//--- test/tb_tomasulo_core.sv
`timescale 1ns/100ps
`include "core_defs.svh"

module tb_tomasulo_core;

	localparam int TIMEOUT = 200;
	localparam int NUM_REGS = 1 << `REG_IDX_W;

	logic clock;
	logic reset;
	logic inst_valid;
	core_pkg::inst_t inst;
	logic issue_stall;
	core_pkg::commit_t commit;

	// reference state and scoreboard
	core_pkg::word_t shadow [NUM_REGS];
	core_pkg::commit_t expected [$];
	logic [31:0] lfsr_state;
	int value_errors;
	int timeout_errors;
	int accept_count;
	int commit_count;
	logic stall_seen;

	tomasulo_core i_tomasulo_core (
		.clock(clock), .reset(reset), .inst_valid(inst_valid), .inst(inst),
		.issue_stall(issue_stall), .commit(commit)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	////////////////////
	// helpers
	////////////////////

	// taps 32 22 2 1 with one step per bit
	function automatic int unsigned take_bits(input int n);
		int unsigned bits;
		logic fb;
		bits = 0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			bits = (bits << 1) | fb;
		end
		return bits;
	endfunction

	// expected result from the isa rules
	function automatic core_pkg::word_t ref_result(input core_pkg::inst_t in,
			input core_pkg::word_t a, input core_pkg::word_t b);
		case (in.op)
			core_pkg::OP_LI: return {{(`WORD_W - `IMM_W){1'b0}}, in.imm};
			core_pkg::OP_ADD: return a + b;
			core_pkg::OP_SUB: return a - b;
			core_pkg::OP_XOR: return a ^ b;
			// low word of the product
			default: return core_pkg::word_t'(a * b);
		endcase
	endfunction

	function automatic core_pkg::inst_t make_inst(input core_pkg::alu_op_t op,
			input int rd, input int rs1, input int rs2, input int imm);
		return '{op: op, rd: core_pkg::reg_idx_t'(rd), rs1: core_pkg::reg_idx_t'(rs1),
			rs2: core_pkg::reg_idx_t'(rs2), imm: core_pkg::imm_t'(imm)};
	endfunction

	task automatic check_commit(input core_pkg::commit_t got, input core_pkg::commit_t exp);
		if (got.rd !== exp.rd || got.value !== exp.value) begin
			value_errors++;
			$display("FAIL at %0t: commit r%0d = %h, expected r%0d = %h", $time,
				got.rd, got.value, exp.rd, exp.value);
		end
	endtask

	task automatic check_level(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAIL at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp) begin
			value_errors++;
			$display("FAIL at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	////////////////////
	// stimulus tasks
	////////////////////

	// called just after a rising edge and returns on one
	task automatic issue(input core_pkg::inst_t in);
		core_pkg::commit_t exp;
		int waited;
		inst_valid <= 1'b1;
		inst <= in;
		waited = 0;
		@(negedge clock);
		while (issue_stall && waited < TIMEOUT) begin
			stall_seen = 1'b1;
			waited++;
			@(negedge clock);
		end
		if (issue_stall) begin
			timeout_errors++;
			$display("instruction was never accepted, issue_stall stuck high at %0t", $time);
		end else begin
			// accepted on the coming edge so model it in program order
			exp.valid = 1'b1;
			exp.rd = in.rd;
			exp.value = ref_result(in, shadow[in.rs1], shadow[in.rs2]);
			shadow[in.rd] = exp.value;
			expected.push_back(exp);
			accept_count++;
		end
		@(posedge clock);
	endtask

	task automatic idle(input int cycles);
		inst_valid <= 1'b0;
		repeat (cycles) @(posedge clock);
	endtask

	task automatic drain();
		int waited;
		idle(1);
		waited = 0;
		while (expected.size() != 0 && waited < TIMEOUT) begin
			waited++;
			@(posedge clock);
		end
		if (expected.size() != 0) begin
			timeout_errors++;
			$display("%0d commits never arrived, waited until %0t", expected.size(), $time);
		end
	endtask

	task automatic finish_run();
		$display("errors: value %0d, timeout %0d, accepted %0d, committed %0d",
			value_errors, timeout_errors, accept_count, commit_count);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	endtask

	////////////////////
	// commit compare
	////////////////////

	always @(negedge clock) begin
		if (!reset && commit.valid) begin
			commit_count++;
			if (expected.size() == 0) begin
				value_errors++;
				$display("FAIL at %0t: commit to r%0d with nothing outstanding", $time,
					commit.rd);
			end else begin
				check_commit(commit, expected.pop_front());
			end
		end
	end

	////////////////////
	// test sequence
	////////////////////

	initial begin
		reset = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		lfsr_state = 32'h07c7_deb9;
		value_errors = 0;
		timeout_errors = 0;
		accept_count = 0;
		commit_count = 0;
		stall_seen = 1'b0;
		for (int r = 0; r < NUM_REGS; r++) shadow[r] = '0;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_level("commit.valid after reset", commit.valid, 1'b0);
		check_level("issue_stall after reset", issue_stall, 1'b0);
		@(posedge clock);

		// registers read as zero before any write
		issue(make_inst(core_pkg::OP_ADD, 0, 3, 5, 0));
		// every register gets an immediate
		for (int r = 0; r < NUM_REGS; r++) begin
			issue(make_inst(core_pkg::OP_LI, r, 0, 0, 8'h11 * (r + 1)));
		end
		drain();

		// dependent chain through the cdb
		issue(make_inst(core_pkg::OP_LI, 1, 0, 0, 5));
		issue(make_inst(core_pkg::OP_LI, 2, 0, 0, 7));
		issue(make_inst(core_pkg::OP_MUL, 3, 1, 2, 0));
		issue(make_inst(core_pkg::OP_ADD, 4, 3, 1, 0));
		issue(make_inst(core_pkg::OP_XOR, 5, 4, 2, 0));
		drain();

		// short add finishes first but retires second
		issue(make_inst(core_pkg::OP_MUL, 6, 5, 3, 0));
		issue(make_inst(core_pkg::OP_ADD, 7, 2, 2, 0));
		drain();

		// repeated renames of r2
		issue(make_inst(core_pkg::OP_MUL, 2, 3, 3, 0));
		issue(make_inst(core_pkg::OP_LI, 2, 0, 0, 9));
		issue(make_inst(core_pkg::OP_ADD, 4, 2, 2, 0));
		issue(make_inst(core_pkg::OP_SUB, 2, 4, 1, 0));
		issue(make_inst(core_pkg::OP_XOR, 5, 2, 4, 0));
		drain();

		// mul burst fills lanes and rob
		stall_seen = 1'b0;
		for (int i = 0; i < 8; i++) begin
			issue(make_inst(core_pkg::OP_MUL, i, (i + 1) % 8, i, 0));
		end
		drain();
		check_level("issue_stall seen during burst", stall_seen, 1'b1);
		check_count("commits versus acceptances", commit_count, accept_count);

		// random mix with idle gaps
		for (int n = 0; n < 300; n++) begin
			issue(make_inst(core_pkg::alu_op_t'(take_bits(3) % 5), take_bits(3), take_bits(3),
				take_bits(3), take_bits(8)));
			if (take_bits(2) == 0) idle(take_bits(2) + 1);
		end
		drain();
		check_count("commits versus acceptances", commit_count, accept_count);
		finish_run();
	end

endmodule

//--- verilog.f
+incdir+design
design/core_pkg.sv
design/issue_stage.sv
design/reservation_lane.sv
design/cdb_arbiter.sv
design/reorder_buffer.sv
design/tomasulo_core.sv
test/tb_tomasulo_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the tomasulo core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
	-f verilog.f \
	--top-module tb_tomasulo_core \
	--Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_tomasulo_core 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "RESULT: PASS"; then
	exit 0
fi
echo "pass message not found"
exit 1
